// ==== Makefile ====
# Verilator build and run of the pattern generator testbench
VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
hdl/logic_hamr_pkg.sv
hdl/pack_if.sv
hdl/mem_rd_if.sv
hdl/pattern_regs.sv
hdl/channel_packer.sv
hdl/pattern_store.sv
hdl/pattern_gen_top.sv
verif/tb_sva.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== hdl/channel_packer.sv ====
// Square-wave packer for one channel, one pixel per clock
// Stretch is sampled at gen_start and held for the whole run
`timescale 1ns/10ps

module channel_packer #(
    parameter bit START_HIGH = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     gen_start,
    input  logic_hamr_pkg::stretch_t stretch,
    pack_if.packer                   pk
);

    localparam int         SHIFT_W   = logic_hamr_pkg::PIXELS_PER_BYTE - 1;
    localparam logic [2:0] LAST_PIX  = 3'(logic_hamr_pkg::PIXELS_PER_BYTE - 1);
    localparam logic [5:0] LAST_BYTE = 6'(logic_hamr_pkg::BYTES_PER_CHANNEL - 1);

    logic                        running;
    logic                        phase;
    logic                        valid_q;
    logic                        done_q;
    logic_hamr_pkg::stretch_t    run_cnt;
    logic_hamr_pkg::stretch_t    stretch_q;
    logic [2:0]                  pix_cnt;
    logic [5:0]                  byte_cnt;
    logic [SHIFT_W-1:0]          shift_q;
    logic_hamr_pkg::hires_byte_t data_q;
    logic                        advance;

    // Stall while an untaken byte is pending
    assign advance = running && !(valid_q && !pk.byte_take);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            phase    <= START_HIGH;
            run_cnt  <= '0;
            pix_cnt  <= '0;
            byte_cnt <= '0;
            valid_q  <= 1'b0;
            done_q   <= 1'b0;
        end else if (gen_start) begin
            running  <= 1'b1;
            phase    <= START_HIGH;
            run_cnt  <= '0;
            pix_cnt  <= '0;
            byte_cnt <= '0;
            valid_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (valid_q && pk.byte_take) begin
                valid_q <= 1'b0;
                // Only the final byte can be pending once stopped
                if (!running) begin
                    done_q <= 1'b1;
                end
            end
            if (advance) begin
                if (run_cnt == stretch_q - 4'd1) begin
                    run_cnt <= '0;
                    phase   <= ~phase;
                end else begin
                    run_cnt <= run_cnt + 4'd1;
                end
                if (pix_cnt == LAST_PIX) begin
                    pix_cnt  <= '0;
                    valid_q  <= 1'b1;
                    byte_cnt <= byte_cnt + 6'd1;
                    if (byte_cnt == LAST_BYTE) begin
                        running <= 1'b0;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 3'd1;
                end
            end
        end
    end

    // Pixel shift register and byte output
    always_ff @(posedge clk) begin
        if (gen_start) begin
            shift_q   <= '0;
            stretch_q <= stretch;
        end else if (advance) begin
            // Earliest pixel drifts down to bit 0
            shift_q <= {phase, shift_q[SHIFT_W-1:1]};
            if (pix_cnt == LAST_PIX) begin
                data_q <= {phase, shift_q};
            end
        end
    end

    assign pk.byte_data  = data_q;
    assign pk.byte_valid = valid_q;
    assign pk.chan_done  = done_q;

endmodule

// ==== hdl/logic_hamr_pkg.sv ====
// Shared constants and types for the HIRES pattern generator
// Linear addresses are 9 bits wide, so channels times bytes must stay below 512
package logic_hamr_pkg;

    // ==================================================
    // Types
    // ==================================================

    // Seven pixels, bit 0 shown first
    typedef logic [6:0] hires_byte_t;
    // Pixels per square-wave sample
    typedef logic [3:0] stretch_t;
    // Channel times bytes per channel plus byte index
    typedef logic [8:0] lin_addr_t;

    // ==================================================
    // Geometry
    // ==================================================

    localparam int NUM_CHANNELS      = 8;
    localparam int BYTES_PER_CHANNEL = 38;
    localparam int PIXELS_PER_BYTE   = 7;
    localparam stretch_t DEFAULT_STRETCH = 4'd3;

    // ==================================================
    // Register map and command codes
    // ==================================================

    localparam logic [3:0] REG_CHANNEL = 4'h0;
    localparam logic [3:0] REG_ADDR    = 4'h1;
    localparam logic [3:0] REG_DATA    = 4'h2;
    localparam logic [3:0] REG_CMD     = 4'h3;
    localparam logic [3:0] REG_STATUS  = 4'h4;
    localparam logic [3:0] REG_STRETCH = 4'h5;

    localparam logic [7:0] CMD_READ_BYTE  = 8'h02;
    localparam logic [7:0] CMD_REGENERATE = 8'h10;

endpackage

// ==== hdl/mem_rd_if.sv ====
// Single-byte read port into the pattern memory
// rd_valid follows rd_req by exactly one cycle
`timescale 1ns/10ps

interface mem_rd_if;

    logic                      rd_req;
    logic_hamr_pkg::lin_addr_t rd_addr;
    logic [7:0]                rd_data;
    logic                      rd_valid;

    modport requester (
        output rd_req,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    modport memory (
        input  rd_req,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

// ==== hdl/pack_if.sv ====
// One packer to store byte channel
// byte_valid holds with stable byte_data until a cycle with byte_take high
`timescale 1ns/10ps

interface pack_if;

    // Packed pixels, bit 7 is added by the store
    logic_hamr_pkg::hires_byte_t byte_data;
    logic                        byte_valid;
    // Transfer completes in any cycle with valid and take both high
    logic                        byte_take;
    // Last byte of the channel taken
    logic                        chan_done;

    modport packer (
        output byte_data,
        output byte_valid,
        output chan_done,
        input  byte_take
    );

    modport store (
        input  byte_data,
        input  byte_valid,
        input  chan_done,
        output byte_take
    );

endinterface

// ==== hdl/pattern_gen_top.sv ====
// HIRES square-wave pattern generator top level
// Host side is a plain one-cycle write strobe with a combinational read mux
`timescale 1ns/10ps

module pattern_gen_top #(
    parameter int NUM_CHANNELS      = logic_hamr_pkg::NUM_CHANNELS,
    parameter int BYTES_PER_CHANNEL = logic_hamr_pkg::BYTES_PER_CHANNEL
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bus_wr,
    input  logic [3:0] bus_addr,
    input  logic [7:0] bus_wdata,
    output logic [7:0] bus_rdata,
    output logic       ready,
    output logic       loading,
    output logic       busy
);

    logic                     gen_start;
    logic_hamr_pkg::stretch_t stretch;
    logic                     all_done;

    pack_if   pk_bus [NUM_CHANNELS] ();
    mem_rd_if rd_bus ();

    // ==================================================
    // Register block
    // ==================================================

    pattern_regs #(
        .NUM_CHANNELS      (NUM_CHANNELS),
        .BYTES_PER_CHANNEL (BYTES_PER_CHANNEL)
    ) regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ready     (ready),
        .loading   (loading),
        .busy      (busy),
        .gen_start (gen_start),
        .stretch   (stretch),
        .all_done  (all_done),
        .rd        (rd_bus)
    );

    // Odd channels start high
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_pack
        channel_packer #(
            .START_HIGH (1'(i % 2))
        ) packer_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .gen_start (gen_start),
            .stretch   (stretch),
            .pk        (pk_bus[i])
        );
    end

    pattern_store #(
        .NUM_CHANNELS      (NUM_CHANNELS),
        .BYTES_PER_CHANNEL (BYTES_PER_CHANNEL)
    ) store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .gen_start (gen_start),
        .all_done  (all_done),
        .pk        (pk_bus),
        .rd        (rd_bus)
    );

endmodule

// ==== hdl/pattern_regs.sv ====
// Host registers, command decode and status
// Commands are dropped while busy; a read byte also needs ready
// ADDR is not range checked against the channel length
`timescale 1ns/10ps

module pattern_regs #(
    parameter int NUM_CHANNELS      = logic_hamr_pkg::NUM_CHANNELS,
    parameter int BYTES_PER_CHANNEL = logic_hamr_pkg::BYTES_PER_CHANNEL
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         bus_wr,
    input  logic [3:0]                   bus_addr,
    input  logic [7:0]                   bus_wdata,
    output logic [7:0]                   bus_rdata,
    output logic                         ready,
    output logic                         loading,
    output logic                         busy,
    output logic                         gen_start,
    output logic_hamr_pkg::stretch_t     stretch,
    input  logic                         all_done,
    mem_rd_if.requester                  rd
);

    localparam int CH_W  = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
    localparam int IDX_W = (BYTES_PER_CHANNEL > 1) ? $clog2(BYTES_PER_CHANNEL) : 1;

    logic [7:0]                chan_q;
    logic [7:0]                addr_q;
    logic [7:0]                data_q;
    logic_hamr_pkg::stretch_t  stretch_q;
    logic                      busy_q;
    logic                      loading_q;
    logic                      ready_q;
    logic                      start_q;
    logic                      req_q;
    logic_hamr_pkg::lin_addr_t req_addr_q;
    logic_hamr_pkg::lin_addr_t lin_addr;
    logic                      cmd_wr;
    logic                      do_read;
    logic                      do_regen;
    logic                      gen_end;

    // ==================================================
    // Command decode
    // ==================================================

    assign cmd_wr   = bus_wr && (bus_addr == logic_hamr_pkg::REG_CMD) && !busy_q;
    assign do_read  = cmd_wr && (bus_wdata == logic_hamr_pkg::CMD_READ_BYTE) && ready_q;
    assign do_regen = cmd_wr && (bus_wdata == logic_hamr_pkg::CMD_REGENERATE);
    // all_done from the previous run is still up while start is pending
    assign gen_end  = loading_q && all_done && !start_q;

    assign lin_addr = logic_hamr_pkg::lin_addr_t'(int'(chan_q[CH_W-1:0]) * BYTES_PER_CHANNEL
                                                  + int'(addr_q[IDX_W-1:0]));

    // Host visible registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_q    <= 8'h00;
            addr_q    <= 8'h00;
            data_q    <= 8'hFF;
            stretch_q <= logic_hamr_pkg::DEFAULT_STRETCH;
        end else begin
            if (bus_wr && bus_addr == logic_hamr_pkg::REG_CHANNEL) begin
                chan_q <= bus_wdata;
            end
            if (bus_wr && bus_addr == logic_hamr_pkg::REG_ADDR) begin
                addr_q <= bus_wdata;
            end
            // Zero stretch would never toggle, so it becomes 1
            if (bus_wr && bus_addr == logic_hamr_pkg::REG_STRETCH) begin
                stretch_q <= (bus_wdata[3:0] == 4'h0) ? 4'h1 : bus_wdata[3:0];
            end
            if (rd.rd_valid) begin
                data_q <= rd.rd_data;
            end
        end
    end

    // ==================================================
    // Busy, loading and ready tracking
    // ==================================================

    // First generation fires straight out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b1;
            loading_q <= 1'b1;
            ready_q   <= 1'b0;
            start_q   <= 1'b1;
            req_q     <= 1'b0;
        end else begin
            start_q <= do_regen;
            req_q   <= do_read;
            if (do_regen) begin
                busy_q    <= 1'b1;
                loading_q <= 1'b1;
                ready_q   <= 1'b0;
            end else if (do_read) begin
                busy_q <= 1'b1;
            end else if (gen_end) begin
                loading_q <= 1'b0;
                ready_q   <= 1'b1;
                busy_q    <= 1'b0;
            end else if (rd.rd_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Address held with the request pulse
    always_ff @(posedge clk) begin
        if (do_read) begin
            req_addr_q <= lin_addr;
        end
    end

    assign rd.rd_req  = req_q;
    assign rd.rd_addr = req_addr_q;
    assign gen_start  = start_q;
    assign stretch    = stretch_q;
    assign busy       = busy_q;
    assign loading    = loading_q;
    assign ready      = ready_q;

    // Read mux
    always_comb begin
        case (bus_addr)
            logic_hamr_pkg::REG_CHANNEL: bus_rdata = chan_q;
            logic_hamr_pkg::REG_ADDR:    bus_rdata = addr_q;
            logic_hamr_pkg::REG_DATA:    bus_rdata = data_q;
            logic_hamr_pkg::REG_CMD:     bus_rdata = 8'h00;
            logic_hamr_pkg::REG_STATUS:  bus_rdata = {6'b0, ready_q, busy_q};
            logic_hamr_pkg::REG_STRETCH: bus_rdata = {4'h0, stretch_q};
            default:                     bus_rdata = 8'hFF;
        endcase
    end

endmodule

// ==== hdl/pattern_store.sv ====
// Round-robin drain of the packers into on-chip pattern memory
// One byte written per cycle; reads return on the following cycle
`timescale 1ns/10ps

module pattern_store #(
    parameter int NUM_CHANNELS      = logic_hamr_pkg::NUM_CHANNELS,
    parameter int BYTES_PER_CHANNEL = logic_hamr_pkg::BYTES_PER_CHANNEL
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      gen_start,
    output logic      all_done,
    pack_if.store     pk [NUM_CHANNELS],
    mem_rd_if.memory  rd
);

    localparam int CH_W  = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
    localparam int IDX_W = (BYTES_PER_CHANNEL > 1) ? $clog2(BYTES_PER_CHANNEL) : 1;
    localparam int DEPTH = NUM_CHANNELS * BYTES_PER_CHANNEL;

    logic [NUM_CHANNELS-1:0]     valid_vec;
    logic [NUM_CHANNELS-1:0]     done_vec;
    logic [NUM_CHANNELS-1:0]     take_vec;
    logic_hamr_pkg::hires_byte_t data_arr [NUM_CHANNELS];
    logic [IDX_W-1:0]            byte_idx [NUM_CHANNELS];
    logic [CH_W-1:0]             rr_ptr;
    logic [CH_W-1:0]             sel;
    logic                        grant;
    logic                        wr_en;
    logic_hamr_pkg::lin_addr_t   wr_addr;
    logic [7:0]                  mem [DEPTH];

    // Flatten the interface array
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_ch
        assign valid_vec[g]    = pk[g].byte_valid;
        assign done_vec[g]     = pk[g].chan_done;
        assign data_arr[g]     = pk[g].byte_data;
        assign pk[g].byte_take = take_vec[g];
    end

    // ==================================================
    // Arbiter
    // ==================================================

    // First valid channel at or after the pointer
    always_comb begin : arb
        int idx;
        grant = 1'b0;
        sel   = '0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= NUM_CHANNELS) begin
                idx = idx - NUM_CHANNELS;
            end
            if (!grant && valid_vec[idx]) begin
                grant = 1'b1;
                sel   = CH_W'(idx);
            end
        end
    end

    // Nothing is taken while a restart is loading the packers
    assign wr_en   = grant && !gen_start;
    assign wr_addr = logic_hamr_pkg::lin_addr_t'(int'(sel) * BYTES_PER_CHANNEL
                                                 + int'(byte_idx[sel]));

    always_comb begin
        take_vec = '0;
        take_vec[sel] = wr_en;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr      <= '0;
            all_done    <= 1'b0;
            rd.rd_valid <= 1'b0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                byte_idx[c] <= '0;
            end
        end else begin
            rd.rd_valid <= rd.rd_req;
            all_done    <= gen_start ? 1'b0 : &done_vec;
            if (gen_start) begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    byte_idx[c] <= '0;
                end
            end else if (wr_en) begin
                byte_idx[sel] <= byte_idx[sel] + 1'b1;
                rr_ptr <= (int'(sel) == NUM_CHANNELS - 1) ? '0 : sel + 1'b1;
            end
        end
    end

    // Memory write with bit 7 cleared, and the read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= {1'b0, data_arr[sel]};
        end
        if (rd.rd_req) begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

endmodule

// ==== verif/tb_checker.sv ====
// Watches the DUT ports, models the registers and compares read data
// Expects the host to hold bus_addr at DATA until busy falls after a read
`timescale 1ns/10ps

module tb_checker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bus_wr,
    input  logic [3:0] bus_addr,
    input  logic [7:0] bus_wdata,
    input  logic [7:0] bus_rdata,
    input  logic       ready,
    input  logic       loading,
    input  logic       busy,
    output int         errors,
    output int         checks
);

    logic [7:0] chan_m;
    logic [7:0] addr_m;
    logic [7:0] data_m;
    logic [3:0] stretch_m;
    // Stretch in force when the stored pattern was generated
    logic [3:0] gen_stretch;
    logic [7:0] pend_byte;
    logic       pend;
    logic       busy_d;
    logic       check_reset;

    // Pixel p = 7*ADDR + k is channel parity XOR parity of p / STRETCH
    function automatic logic [7:0] expected_byte(input logic [7:0] chan, input logic [7:0] addr,
                                                 input logic [3:0] str);
        int p;
        int pix;
        logic [7:0] b;
        b = 8'h00;
        for (int k = 0; k < 7; k++) begin
            p = 7 * int'(addr[5:0]) + k;
            pix = int'(chan[0]) ^ ((p / int'(str)) % 2);
            b[k] = pix[0];
        end
        return b;
    endfunction

    task automatic compare(input string reg_name, input logic [7:0] exp);
        checks = checks + 1;
        if (bus_rdata !== exp) begin
            errors = errors + 1;
            $display("** Error bus_rdata (%s) at %0t: expected 0x%02h, got 0x%02h",
                     reg_name, $time, exp, bus_rdata);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            chan_m      = 8'h00;
            addr_m      = 8'h00;
            data_m      = 8'hFF;
            stretch_m   = logic_hamr_pkg::DEFAULT_STRETCH;
            gen_stretch = logic_hamr_pkg::DEFAULT_STRETCH;
            pend        = 1'b0;
            busy_d      = 1'b1;
            check_reset = 1'b1;
            errors      = 0;
            checks      = 0;
        end else begin
            // First cycle out of reset
            if (check_reset) begin
                checks = checks + 1;
                if (!(busy && loading && !ready)) begin
                    errors = errors + 1;
                    $display("Reset state wrong: busy=%b loading=%b ready=%b", busy, loading, ready);
                end
                check_reset = 1'b0;
            end
            // Read completes as busy falls
            if (pend && busy_d && !busy) begin
                data_m = pend_byte;
                pend   = 1'b0;
            end
            // ==================================================
            // Register readback
            // ==================================================
            if (!bus_wr) begin
                case (bus_addr)
                    logic_hamr_pkg::REG_CHANNEL: compare("CHANNEL", chan_m);
                    logic_hamr_pkg::REG_ADDR:    compare("ADDR", addr_m);
                    logic_hamr_pkg::REG_STRETCH: compare("STRETCH", {4'h0, stretch_m});
                    logic_hamr_pkg::REG_DATA: begin
                        if (!busy) compare("DATA", data_m);
                    end
                    logic_hamr_pkg::REG_STATUS: begin
                        if (ready && !busy) compare("STATUS", 8'h02);
                    end
                    default: ;
                endcase
            end
            // ==================================================
            // Bus write tracking
            // ==================================================
            if (bus_wr) begin
                case (bus_addr)
                    logic_hamr_pkg::REG_CHANNEL: chan_m = bus_wdata;
                    logic_hamr_pkg::REG_ADDR:    addr_m = bus_wdata;
                    logic_hamr_pkg::REG_STRETCH: begin
                        stretch_m = (bus_wdata[3:0] == 4'h0) ? 4'h1 : bus_wdata[3:0];
                    end
                    logic_hamr_pkg::REG_CMD: begin
                        // Commands while busy are dropped
                        if (!busy && bus_wdata == logic_hamr_pkg::CMD_REGENERATE) begin
                            gen_stretch = stretch_m;
                        end else if (!busy && ready
                                     && bus_wdata == logic_hamr_pkg::CMD_READ_BYTE) begin
                            pend      = 1'b1;
                            pend_byte = expected_byte(chan_m, addr_m, gen_stretch);
                        end
                    end
                    default: ;
                endcase
            end
            busy_d = busy;
        end
    end

endmodule

// ==== verif/tb_sva.sv ====
// Register block assertions, bound into every pattern_regs instance
// Inactive while rst_n is low
`timescale 1ns/10ps

module tb_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       bus_wr,
    input logic [3:0] bus_addr,
    input logic [7:0] bus_wdata,
    input logic       busy,
    input logic       loading,
    input logic       ready
);

    logic cmd_go;
    logic regen_go;
    logic read_go;
    // Failed assertion count
    int   fail_count = 0;

    // Command strobes that must be accepted
    assign cmd_go   = bus_wr && (bus_addr == logic_hamr_pkg::REG_CMD) && !busy;
    assign regen_go = cmd_go && (bus_wdata == logic_hamr_pkg::CMD_REGENERATE);
    assign read_go  = cmd_go && (bus_wdata == logic_hamr_pkg::CMD_READ_BYTE) && ready;

    // Ready overlaps busy only for the two cycles of a byte read
    ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ready && busy |-> ##[1:2] !busy)
        else begin
            $error("ready and busy stayed high together beyond a byte read");
            fail_count++;
        end

    // Busy and loading rise and ready falls on the next cycle
    regen_busy: assert property (@(posedge clk) disable iff (!rst_n)
        regen_go |=> busy && loading && !ready)
        else begin
            $error("regenerate while idle did not raise busy and loading and drop ready");
            fail_count++;
        end

    // Busy for two sampled cycles, low on the third
    read_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $past(read_go, 3) |-> !busy && $past(busy) && $past(busy, 2))
        else begin
            $error("read command did not finish exactly 2 cycles after the strobe");
            fail_count++;
        end

    loading_busy: assert property (@(posedge clk) disable iff (!rst_n) loading |-> busy)
        else begin
            $error("loading high while busy is low");
            fail_count++;
        end

endmodule

bind pattern_regs tb_sva sva_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_wr    (bus_wr),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .busy      (busy),
    .loading   (loading),
    .ready     (ready)
);

// ==== verif/tb_top.sv ====
// Testbench top for the HIRES pattern generator
// Every wait is bounded; a timeout counts as a failure and the run goes on
`timescale 1ns/10ps

module tb_top;

    localparam logic [31:0] SEED         = 32'h64510a14;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          READS_PER_CH = 2;
    localparam int          NUM_TESTS    = 5;
    localparam int          NUM_CH       = logic_hamr_pkg::NUM_CHANNELS;
    localparam int          NUM_BYTES    = logic_hamr_pkg::BYTES_PER_CHANNEL;

    logic        clk;
    logic        rst_n;
    logic        bus_wr;
    logic [3:0]  bus_addr;
    logic [7:0]  bus_wdata;
    logic [7:0]  bus_rdata;
    logic        ready;
    logic        loading;
    logic        busy;
    int          errors;
    int          checks;
    int          timeouts;
    int          sva_fails;
    int          bad_mark;
    logic [31:0] lfsr;

    pattern_gen_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ready     (ready),
        .loading   (loading),
        .busy      (busy)
    );

    tb_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_wr    (bus_wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ready     (ready),
        .loading   (loading),
        .busy      (busy),
        .errors    (errors),
        .checks    (checks)
    );

    // Assertion failures from the bound register checker
    assign sva_fails = dut_i.regs_i.sva_i.fail_count;

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Random bits and bus tasks
    // ==================================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        bus_wr    <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_wr <= 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (busy && n < WAIT_LIMIT);
        if (busy) begin
            timeouts++;
            $display("Timeout: busy still high after %0d cycles (%s)", n, what);
        end
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ready && n < WAIT_LIMIT);
        if (!ready) begin
            timeouts++;
            $display("Timeout: ready never rose within %0d cycles (%s)", n, what);
        end
    endtask

    // Checker compares DATA once busy falls
    task automatic read_byte(input int ch, input int idx);
        write_reg(logic_hamr_pkg::REG_CHANNEL, 8'(ch));
        write_reg(logic_hamr_pkg::REG_ADDR, 8'(idx));
        write_reg(logic_hamr_pkg::REG_CMD, logic_hamr_pkg::CMD_READ_BYTE);
        bus_addr <= logic_hamr_pkg::REG_DATA;
        wait_idle("read byte");
    endtask

    task automatic read_all();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int idx = 0; idx < NUM_BYTES; idx++) begin
                read_byte(ch, idx);
            end
        end
    endtask

    task automatic regenerate(input int str);
        write_reg(logic_hamr_pkg::REG_STRETCH, 8'(str));
        write_reg(logic_hamr_pkg::REG_CMD, logic_hamr_pkg::CMD_REGENERATE);
    endtask

    task automatic finish_test(input int num, input string name);
        int bad;
        string verdict;
        @(posedge clk);
        @(negedge clk);
        bad = errors + timeouts + sva_fails - bad_mark;
        bad_mark = errors + timeouts + sva_fails;
        verdict = (bad == 0) ? "ok" : "failed";
        $display("Test %0d %s: %s (%0d problems)", num, name, verdict, bad);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int val;
        int s1;
        int s2;
        rst_n     = 1'b0;
        bus_wr    = 1'b0;
        bus_addr  = logic_hamr_pkg::REG_STATUS;
        bus_wdata = 8'h00;
        lfsr      = SEED;
        timeouts  = 0;
        bad_mark  = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Generation starts by itself, STATUS read once ready
        wait_ready("first generation");
        finish_test(1, "reset and first generation");

        draw(8, val);
        write_reg(logic_hamr_pkg::REG_CHANNEL, 8'(val));
        draw(8, val);
        write_reg(logic_hamr_pkg::REG_ADDR, 8'(val));
        write_reg(logic_hamr_pkg::REG_STRETCH, 8'h00);
        draw(8, val);
        write_reg(logic_hamr_pkg::REG_STRETCH, 8'(val));
        finish_test(2, "register readback");

        // Pattern still from reset, stretch 3
        for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int r = 0; r < READS_PER_CH; r++) begin
                draw(6, val);
                read_byte(ch, val % NUM_BYTES);
            end
        end
        finish_test(3, "random reads at stretch 3");

        draw(4, val);
        s1 = val % 15 + 1;
        regenerate(s1);
        wait_ready("regenerate");
        read_all();
        finish_test(4, "regenerate and full readout");

        // Read, stretch write and regenerate all land while busy
        draw(4, val);
        s1 = val % 15 + 1;
        s2 = s1 % 15 + 1;
        regenerate(s1);
        write_reg(logic_hamr_pkg::REG_CMD, logic_hamr_pkg::CMD_READ_BYTE);
        regenerate(s2);
        bus_addr <= logic_hamr_pkg::REG_DATA;
        wait_ready("regenerate with dropped commands");
        @(posedge clk);
        read_all();
        finish_test(5, "commands while busy");

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d timeouts, %0d assertion fails",
                 NUM_TESTS, checks, errors, timeouts, sva_fails);
        if (errors == 0 && timeouts == 0 && sva_fails == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
